//--- mmioClient.f
common/mmioPkg.sv
rtl/mmioBusDecoder.sv
regfile/mmioRegFile.sv
rtl/mmioReadMux.sv
rtl/mmioClient.sv
sim/mmioClientTb.sv

//--- run.sh
#!/bin/sh
# Build and run the MMIO client testbench with Verilator

cd "$(dirname "$0")" || exit 1

# Compile the testbench and DUT into one binary
verilator --binary --timing --assert -j 0 \
  --top-module mmioClientTb \
  -f mmioClient.f \
  -o mmioClientSim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

# Run and keep the output in memory
output=$(./obj_dir/mmioClientSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation binary returned status $status"
  exit 1
fi

# Verdict from the testbench output
if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
  exit 0
else
  exit 1
fi

//--- sim/mmioClientTb.sv
// MMIO client testbench with clock, reset, stimulus table, reference image and checks
module mmioClientTb;
  timeunit 1ns;
  timeprecision 1ps;

  // Entry kinds
  localparam logic [1:0] kIdle  = 2'd0;
  localparam logic [1:0] kWrite = 2'd1;
  localparam logic [1:0] kRead  = 2'd2;
  localparam logic [1:0] kWrRd  = 2'd3;   // Write and a gapless read of the same byte
  localparam int cResetCycles   = 4;

  typedef struct packed {
    logic [1:0] kind;
    logic [7:0] addr;    // Full bus address including bit 7
    logic [7:0] data;
    logic [7:0] expRd;
    logic [7:0] mask;    // Zero skips the rdData check
    logic [3:0] stat;    // Qpll lock, core ready, mc1 and mc0 from the top bit down
  } entryT;

  // DUT signals
  logic        shlClk;
  logic        rst;
  logic        csN;
  logic        weN;
  logic [7:0]  addr;
  logic [7:0]  wrData;
  logic [7:0]  rdData;
  logic        mc0InitCalComplete;
  logic        mc1InitCalComplete;
  logic        eth0CoreReady;
  logic        eth0QpllLock;
  logic [15:0] roleRegIn;
  logic [31:0] smcReg;
  logic        eth0RxEqualizerMode;
  logic [3:0]  eth0TxDriverSwing;
  logic [4:0]  eth0TxPreCursor;
  logic [4:0]  eth0TxPostCursor;
  logic        eth0PcsLoopbackEn;
  logic        eth0MacLoopbackEn;
  logic        eth0MacAddrSwapEn;
  logic [47:0] nts0MacAddress;
  logic [31:0] nts0IpAddress;
  logic [15:0] roleRegOut;

  entryT      stimTable [$];
  logic [7:0] modelImg [0:127];   // Expected control image
  logic [3:0] statBits;           // Status inputs stamped into new entries
  int         readErrors;
  int         fieldErrors;
  int         cycleCount;
  int         cycleLimit;
  int         seed = 38529;

  // Control writes with their field meaning
  logic [7:0] fieldAddr [18] = '{8'h11, 8'h12, 8'h13, 8'h20, 8'h22, 8'h23, 8'h24, 8'h25, 8'h26,
                                 8'h27, 8'h30, 8'h34, 8'h35, 8'h36, 8'h37, 8'h42, 8'h43, 8'h74};
  logic [7:0] fieldData [18] = '{8'hA3, 8'h1F, 8'hEC, 8'h81, 8'h10, 8'h32, 8'h54, 8'h76, 8'h98,
                                 8'hBA, 8'h7E, 8'h0A, 8'h01, 8'hA8, 8'hC0, 8'h34, 8'h12, 8'h05};

  mmioClient mmioClient_i (
    .shlClk              (shlClk),
    .rst                 (rst),
    .csN                 (csN),
    .weN                 (weN),
    .addr                (addr),
    .wrData              (wrData),
    .rdData              (rdData),
    .mc0InitCalComplete  (mc0InitCalComplete),
    .mc1InitCalComplete  (mc1InitCalComplete),
    .eth0CoreReady       (eth0CoreReady),
    .eth0QpllLock        (eth0QpllLock),
    .roleRegIn           (roleRegIn),
    .smcReg              (smcReg),
    .eth0RxEqualizerMode (eth0RxEqualizerMode),
    .eth0TxDriverSwing   (eth0TxDriverSwing),
    .eth0TxPreCursor     (eth0TxPreCursor),
    .eth0TxPostCursor    (eth0TxPostCursor),
    .eth0PcsLoopbackEn   (eth0PcsLoopbackEn),
    .eth0MacLoopbackEn   (eth0MacLoopbackEn),
    .eth0MacAddrSwapEn   (eth0MacAddrSwapEn),
    .nts0MacAddress      (nts0MacAddress),
    .nts0IpAddress       (nts0IpAddress),
    .roleRegOut          (roleRegOut)
  );

  // ==================================================================
  // Clock and cycle limit
  // ==================================================================
  always
  begin
    #50 shlClk = ~shlClk;   // 100 ns period
  end

  always @(posedge shlClk)
  begin
    cycleCount++;
    if (cycleLimit != 0 && cycleCount > cycleLimit)
    begin
      $display("Timeout: the stimulus table did not finish within %0d cycles", cycleLimit);
      $display("Simulation failed");
      $finish;
    end
  end

  // ==================================================================
  // Reference rules of the register map
  // ==================================================================
  function automatic logic [7:0] resetByte(input logic [6:0] a);
    case (a)
      7'h00: return 8'h3C;   // User variant identity
      7'h01: return 8'h01;
      7'h11: return 8'h41;   // Swing 4 with equalizer on
      7'h12: return 8'h05;
      7'h13: return 8'h05;
      7'h70: return 8'hDE;
      7'h71: return 8'hAD;
      7'h72: return 8'hBE;
      7'h73: return 8'hEF;
      default: return 8'h00;
    endcase
  endfunction

  function automatic bit storedSlot(input logic [6:0] a);
    case (a)
      7'h00, 7'h01, 7'h02, 7'h11, 7'h12, 7'h13:
        return 1'b1;
      7'h20, 7'h22, 7'h23, 7'h24, 7'h25, 7'h26, 7'h27:
        return 1'b1;
      7'h30, 7'h34, 7'h35, 7'h36, 7'h37, 7'h42, 7'h43:
        return 1'b1;
      7'h70, 7'h71, 7'h72, 7'h73, 7'h74:
        return 1'b1;
      default:
        return 1'b0;   // Status spare and unmapped slots
    endcase
  endfunction

  // Upper space and read-only slots leave the image alone
  task automatic applyWrite(input logic [7:0] a, input logic [7:0] d);
    if (!a[7] && storedSlot(a[6:0]))
    begin
      modelImg[a[6:0]] = d;
    end
  endtask

  // ==================================================================
  // Table construction
  // ==================================================================
  task automatic appendEntry(input logic [1:0] kind, input logic [7:0] a, input logic [7:0] d,
                             input logic [7:0] e, input logic [7:0] m);
    entryT ent;
    ent.kind  = kind;
    ent.addr  = a;
    ent.data  = d;
    ent.expRd = e;
    ent.mask  = m;
    ent.stat  = statBits;
    stimTable.push_back(ent);
  endtask

  task automatic writeStep(input logic [7:0] a, input logic [7:0] d);
    appendEntry(kWrite, a, d, 8'h00, 8'h00);
  endtask

  task automatic readStep(input logic [7:0] a, input logic [7:0] e);
    appendEntry(kRead, a, 8'h00, e, 8'hFF);
  endtask

  task automatic buildTable();
    int rnd;
    statBits = 4'b1101;
    appendEntry(kIdle, 8'h00, 8'h00, 8'h00, 8'h00);
    // Defaults of every stored byte
    for (int a = 0; a < 128; a++)
    begin
      if (storedSlot(7'(a)))
      begin
        readStep(8'(a), resetByte(7'(a)));
      end
    end
    // Field writes followed by read-back
    for (int k = 0; k < 18; k++)
    begin
      writeStep(fieldAddr[k], fieldData[k]);
    end
    for (int k = 0; k < 18; k++)
    begin
      readStep(fieldAddr[k], fieldData[k]);
    end
    // Each status bit alone, mc0 in bit 0 up to qpll lock in bit 3
    for (int b = 0; b < 4; b++)
    begin
      statBits = 4'b0001 << b;
      readStep(8'h10, 8'h01 << b);
    end
    statBits = 4'b1101;   // Qpll lock, core ready and mc0 high
    readStep(8'h10, 8'h0D);
    readStep(8'h40, 8'h5A);
    readStep(8'h41, 8'hA5);
    readStep(8'h44, 8'h78);
    readStep(8'h45, 8'h56);
    readStep(8'h46, 8'h34);
    readStep(8'h47, 8'h12);
    writeStep(8'h10, 8'hFF);   // Read-only so nothing sticks
    writeStep(8'h40, 8'hFF);
    writeStep(8'h44, 8'hFF);
    writeStep(8'h50, 8'hAA);   // Spare
    readStep(8'h10, 8'h0D);
    readStep(8'h40, 8'h5A);
    readStep(8'h44, 8'h78);
    readStep(8'h50, 8'h00);
    // Upper half ignored and rdData keeps the last read
    writeStep(8'h91, 8'h00);
    writeStep(8'hF4, 8'h07);
    readStep(8'h11, 8'hA3);
    readStep(8'h80, 8'hA3);
    readStep(8'hA2, 8'hA3);
    // Back-to-back scratch traffic
    for (int k = 0; k < 8; k++)
    begin
      rnd = $random(seed);
      appendEntry(kWrRd, 8'h70 + 8'(k % 4), rnd[7:0], rnd[7:0], 8'hFF);
    end
  endtask

  // ==================================================================
  // Bus driving and checks
  // ==================================================================
  task automatic driveBus(input logic isWrite, input logic [7:0] a, input logic [7:0] d);
    csN    = 1'b0;
    weN    = !isWrite;
    addr   = a;
    wrData = d;
  endtask

  task automatic driveIdle();
    csN = 1'b1;
    weN = 1'b1;
  endtask

  task automatic compareValue(input string sigName, input logic [47:0] expVal,
                              input logic [47:0] actVal, input bit isRead);
    assert (actVal === expVal)
    else
    begin
      $display("[FAIL] t=%0d ns %s expected %0h actual %0h", $time, sigName, expVal, actVal);
      if (isRead)
      begin
        readErrors++;
      end
      else
      begin
        fieldErrors++;
      end
    end
  endtask

  task automatic checkFields();
    compareValue("eth0RxEqualizerMode", 48'(modelImg[7'h11][0]),
                 48'(eth0RxEqualizerMode), 1'b0);
    compareValue("eth0TxDriverSwing", 48'(modelImg[7'h11][7:4]), 48'(eth0TxDriverSwing), 1'b0);
    compareValue("eth0TxPreCursor", 48'(modelImg[7'h12][4:0]), 48'(eth0TxPreCursor), 1'b0);
    compareValue("eth0TxPostCursor", 48'(modelImg[7'h13][4:0]), 48'(eth0TxPostCursor), 1'b0);
    compareValue("eth0PcsLoopbackEn", 48'(modelImg[7'h74][0]), 48'(eth0PcsLoopbackEn), 1'b0);
    compareValue("eth0MacLoopbackEn", 48'(modelImg[7'h74][1]), 48'(eth0MacLoopbackEn), 1'b0);
    compareValue("eth0MacAddrSwapEn", 48'(modelImg[7'h74][2]), 48'(eth0MacAddrSwapEn), 1'b0);
    compareValue("nts0MacAddress", {modelImg[7'h27], modelImg[7'h26], modelImg[7'h25],
                 modelImg[7'h24], modelImg[7'h23], modelImg[7'h22]}, nts0MacAddress, 1'b0);
    compareValue("nts0IpAddress", 48'({modelImg[7'h37], modelImg[7'h36], modelImg[7'h35],
                 modelImg[7'h34]}), 48'(nts0IpAddress), 1'b0);
    compareValue("roleRegOut", 48'({modelImg[7'h43], modelImg[7'h42]}), 48'(roleRegOut), 1'b0);
  endtask

  // ==================================================================
  // Main sequence
  // ==================================================================
  initial
  begin
    entryT ent;
    shlClk             = 1'b0;
    rst                = 1'b1;
    csN                = 1'b1;
    weN                = 1'b1;
    addr               = 8'h00;
    wrData             = 8'h00;
    mc0InitCalComplete = 1'b1;   // Fixed status pattern
    mc1InitCalComplete = 1'b0;
    eth0CoreReady      = 1'b1;
    eth0QpllLock       = 1'b1;
    roleRegIn          = 16'hA55A;
    smcReg             = 32'h12345678;
    readErrors         = 0;
    fieldErrors        = 0;
    cycleCount         = 0;
    for (int a = 0; a < 128; a++)
    begin
      modelImg[a] = resetByte(7'(a));
    end
    buildTable();
    cycleLimit = 3 * stimTable.size() + cResetCycles + 20;

    repeat (cResetCycles) @(negedge shlClk);
    rst = 1'b0;
    compareValue("rdData", 48'h0, 48'(rdData), 1'b1);   // Cleared by reset
    checkFields();

    for (int i = 0; i < stimTable.size(); i++)
    begin
      ent = stimTable[i];
      {eth0QpllLock, eth0CoreReady, mc1InitCalComplete, mc0InitCalComplete} = ent.stat;
      if (ent.kind == kIdle)
      begin
        driveIdle();
      end
      else
      begin
        driveBus(ent.kind != kRead, ent.addr, ent.data);
      end
      if (ent.kind == kWrite || ent.kind == kWrRd)
      begin
        applyWrite(ent.addr, ent.data);
      end
      @(negedge shlClk);
      if (ent.kind == kWrRd)
      begin
        driveBus(1'b0, ent.addr, 8'h00);   // Read right behind the write
        @(negedge shlClk);
      end
      driveIdle();
      @(negedge shlClk);   // Two rising edges after the last access
      if (ent.mask != 8'h00)
      begin
        compareValue("rdData", 48'(ent.expRd & ent.mask), 48'(rdData & ent.mask), 1'b1);
      end
      checkFields();
    end

    $display("Errors: read %0d, field %0d, total %0d", readErrors, fieldErrors,
             readErrors + fieldErrors);
    if (readErrors + fieldErrors == 0)
    begin
      $display("Simulation passed");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- rtl/mmioClient.sv
// MMIO client top: bus decoder, register file, read-back mux and control field slicing
module mmioClient (
  // Shell clock and reset
  input  logic                 shlClk,
  input  logic                 rst,
  // Byte bus from the board controller
  input  logic                 csN,
  input  logic                 weN,
  input  logic [mmioPkg::cAddrWidth:0] addr,
  input  mmioPkg::regByteT     wrData,
  output mmioPkg::regByteT     rdData,
  // Status inputs
  input  logic                 mc0InitCalComplete,
  input  logic                 mc1InitCalComplete,
  input  logic                 eth0CoreReady,
  input  logic                 eth0QpllLock,
  input  logic [15:0]          roleRegIn,
  input  logic [31:0]          smcReg,
  // ETH0 transceiver tuning
  output logic                 eth0RxEqualizerMode,
  output logic [3:0]           eth0TxDriverSwing,
  output logic [4:0]           eth0TxPreCursor,
  output logic [4:0]           eth0TxPostCursor,
  // Loopback controls
  output logic                 eth0PcsLoopbackEn,
  output logic                 eth0MacLoopbackEn,
  output logic                 eth0MacAddrSwapEn,
  // Network stack addresses
  output logic [47:0]          nts0MacAddress,
  output logic [31:0]          nts0IpAddress,
  // Role control word
  output logic [15:0]          roleRegOut
);

  import mmioPkg::*;

  logic    wrEn;       // Write pulse, one cycle after the bus sample
  logic    rdEn;       // Read pulse, same stage
  regAddrT regAddr;
  regByteT regWrData;
  ctrlVecT ctrlVec;    // Live control image

  // ==================================================================
  // Pipeline blocks
  // ==================================================================
  mmioBusDecoder busDecoder_i (
    .shlClk    (shlClk),
    .rst       (rst),
    .csN       (csN),
    .weN       (weN),
    .addr      (addr),
    .wrData    (wrData),
    .wrEn      (wrEn),
    .rdEn      (rdEn),
    .regAddr   (regAddr),
    .regWrData (regWrData)
  );

  mmioRegFile regFile_i (
    .shlClk    (shlClk),
    .rst       (rst),
    .wrEn      (wrEn),
    .regAddr   (regAddr),
    .regWrData (regWrData),
    .ctrlVec   (ctrlVec)
  );

  mmioReadMux readMux_i (
    .shlClk             (shlClk),
    .rst                (rst),
    .rdEn               (rdEn),
    .regAddr            (regAddr),
    .ctrlVec            (ctrlVec),
    .mc0InitCalComplete (mc0InitCalComplete),
    .mc1InitCalComplete (mc1InitCalComplete),
    .eth0CoreReady      (eth0CoreReady),
    .eth0QpllLock       (eth0QpllLock),
    .roleRegIn          (roleRegIn),
    .smcReg             (smcReg),
    .rdData             (rdData)
  );

  // ==================================================================
  // Control fields out of the image
  // ==================================================================
  assign eth0RxEqualizerMode = ctrlVec[PHY_ETH0_0][0];
  assign eth0TxDriverSwing   = ctrlVec[PHY_ETH0_0][7:4];
  assign eth0TxPreCursor     = ctrlVec[PHY_ETH0_1][4:0];
  assign eth0TxPostCursor    = ctrlVec[PHY_ETH0_2][4:0];

  assign eth0PcsLoopbackEn = ctrlVec[DIAG_CTRL][0];
  assign eth0MacLoopbackEn = ctrlVec[DIAG_CTRL][1];
  assign eth0MacAddrSwapEn = ctrlVec[DIAG_CTRL][2];

  // MAC0 and IP0 land in the low byte
  assign nts0MacAddress = {ctrlVec[LY2_MAC5], ctrlVec[LY2_MAC4], ctrlVec[LY2_MAC3],
                           ctrlVec[LY2_MAC2], ctrlVec[LY2_MAC1], ctrlVec[LY2_MAC0]};
  assign nts0IpAddress  = {ctrlVec[LY3_IP3], ctrlVec[LY3_IP2],
                           ctrlVec[LY3_IP1], ctrlVec[LY3_IP0]};

  assign roleRegOut = {ctrlVec[ROLE_OUT1], ctrlVec[ROLE_OUT0]};  // OUT0 is the low byte

endmodule

//--- rtl/mmioReadMux.sv
// Read-back path: status merge over the control image and the registered read data
module mmioReadMux (
  input  logic             shlClk,
  input  logic             rst,
  input  logic             rdEn,                // Read pulse from the decoder
  input  mmioPkg::regAddrT regAddr,
  input  mmioPkg::ctrlVecT ctrlVec,             // Stored control bytes
  // Status inputs, sampled when the read is served
  input  logic             mc0InitCalComplete,
  input  logic             mc1InitCalComplete,
  input  logic             eth0CoreReady,
  input  logic             eth0QpllLock,
  input  logic [15:0]      roleRegIn,
  input  logic [31:0]      smcReg,
  output mmioPkg::regByteT rdData
);

  import mmioPkg::*;

  regAddrE rdSel;   // Address seen as a map entry
  regByteT rdByte;  // Byte picked for this read
  regByteT phyStat;

  assign rdSel = regAddrE'(regAddr);

  // Link and calibration bits in the low nibble
  assign phyStat = {{(cDataWidth-4){1'b0}},
                    eth0QpllLock,
                    eth0CoreReady,
                    mc1InitCalComplete,
                    mc0InitCalComplete};

  // ==================================================================
  // Byte select
  // ==================================================================
  always_comb
  begin
    rdByte = ctrlVec[regAddr];  // Zero for unstored slots
    case (rdSel)
      PHY_STAT:
        rdByte = phyStat;
      // Role input word, low byte first
      ROLE_IN0:
        rdByte = roleRegIn[7:0];
      ROLE_IN1:
        rdByte = roleRegIn[15:8];
      // SMC word, least significant byte first
      SMC0:
        rdByte = smcReg[7:0];
      SMC1:
        rdByte = smcReg[15:8];
      SMC2:
        rdByte = smcReg[23:16];
      SMC3:
        rdByte = smcReg[31:24];
      default:
        ;   // Keep the control byte
    endcase
  end

  // ==================================================================
  // Read data register
  // ==================================================================
  always_ff @(posedge shlClk)
  begin
    if (rst)
    begin
      rdData <= '0;
    end
    else if (rdEn)
    begin
      rdData <= rdByte;  // Held until the next read
    end
  end

endmodule

//--- regfile/mmioRegFile.sv
// Control register storage: one byte flop per writable slot, reset defaults, zeros elsewhere
module mmioRegFile (
  input  logic             shlClk,
  input  logic             rst,
  input  logic             wrEn,       // From the decoder stage
  input  mmioPkg::regAddrT regAddr,
  input  mmioPkg::regByteT regWrData,
  output mmioPkg::ctrlVecT ctrlVec     // Full 128-byte image
);

  import mmioPkg::*;

  // ==================================================================
  // Slot generation
  // ==================================================================
  // Each slot is checked against the write rule at elaboration time.
  // Writable ones get a byte register, the rest tie to zero.
  for (genvar i = 0; i < cRegCount; i++)
  begin : genSlot
    localparam regAddrT cSlotAddr = regAddrT'(i);

    if (isWritable(cSlotAddr))
    begin : genRw
      regByteT slotQ;   // Stored byte
      logic    slotWr;  // Write hit on this slot

      assign slotWr = wrEn && (regAddr == cSlotAddr);

      always_ff @(posedge shlClk)
      begin
        if (rst)
        begin
          slotQ <= defaultValue(cSlotAddr);  // Identity, tuning and scratch patterns
        end
        else if (slotWr)
        begin
          slotQ <= regWrData;
        end
      end

      assign ctrlVec[i] = slotQ;
    end
    else
    begin : genRo
      // Status, spare or unmapped
      assign ctrlVec[i] = '0;
    end
  end

  // Writes to status or spare slots simply find no register above,
  // so the write pulse is dropped there and the image is unchanged.
  // Status bytes are merged later by the read mux, not stored here.

endmodule

//--- rtl/mmioBusDecoder.sv
// Bus sampling stage: strobe qualification, address and data capture, write and read pulses
module mmioBusDecoder (
  input  logic                         shlClk,
  input  logic                         rst,
  input  logic                         csN,      // Active low select
  input  logic                         weN,      // Low for a write
  input  logic [mmioPkg::cAddrWidth:0] addr,     // Top bit picks the upper space
  input  mmioPkg::regByteT             wrData,
  output logic                         wrEn,
  output logic                         rdEn,
  output mmioPkg::regAddrT             regAddr,
  output mmioPkg::regByteT             regWrData
);

  import mmioPkg::*;

  logic lowerSel;  // Access to the register map this cycle

  // Upper half is not decoded here
  assign lowerSel = !csN && !addr[cAddrWidth];

  // ==================================================================
  // Strobe stage
  // ==================================================================
  always_ff @(posedge shlClk)
  begin
    if (rst)
    begin
      wrEn <= 1'b0;
      rdEn <= 1'b0;
    end
    else
    begin
      wrEn <= lowerSel && !weN;   // One-cycle pulse per access
      rdEn <= lowerSel &&  weN;
    end
  end

  // Address and data follow the strobes, only captured on a real access
  always_ff @(posedge shlClk)
  begin
    if (lowerSel)
    begin
      regAddr   <= addr[cAddrWidth-1:0];
      regWrData <= wrData;        // Don't care on reads
    end
  end

endmodule

//--- common/mmioPkg.sv
// Bus widths, register types, address map enum, reset defaults and write rule
package mmioPkg;

  // ==================================================================
  // Widths
  // ==================================================================
  localparam int cAddrWidth = 7;               // Lower space index, bit 7 is the page bit
  localparam int cDataWidth = 8;               // One register byte
  localparam int cRegCount  = 2**cAddrWidth;   // 128 slots

  typedef logic [cDataWidth-1:0] regByteT;
  typedef logic [cAddrWidth-1:0] regAddrT;
  typedef regByteT [cRegCount-1:0] ctrlVecT;   // Whole control image, slot 0 in the low byte

  // ==================================================================
  // Register map of the lower address space
  // ==================================================================
  typedef enum regAddrT {
    // Product identity
    CFG_VPD_ID    = 7'h00,
    CFG_VPD_VER   = 7'h01,
    CFG_VPD_REV   = 7'h02,
    // Physical layer
    PHY_STAT      = 7'h10,  // Read-only link and calibration bits
    PHY_ETH0_0    = 7'h11,  // Swing and Rx equalizer
    PHY_ETH0_1    = 7'h12,  // Tx pre-cursor
    PHY_ETH0_2    = 7'h13,  // Tx post-cursor
    // Layer 2
    LY2_CTRL      = 7'h20,
    LY2_MAC0      = 7'h22,  // MAC address, LSB first
    LY2_MAC1      = 7'h23,
    LY2_MAC2      = 7'h24,
    LY2_MAC3      = 7'h25,
    LY2_MAC4      = 7'h26,
    LY2_MAC5      = 7'h27,
    // Layer 3
    LY3_CTRL0     = 7'h30,
    LY3_IP0       = 7'h34,  // IP address, LSB first
    LY3_IP1       = 7'h35,
    LY3_IP2       = 7'h36,
    LY3_IP3       = 7'h37,
    // Role exchange and SMC word
    ROLE_IN0      = 7'h40,
    ROLE_IN1      = 7'h41,
    ROLE_OUT0     = 7'h42,
    ROLE_OUT1     = 7'h43,
    SMC0          = 7'h44,
    SMC1          = 7'h45,
    SMC2          = 7'h46,
    SMC3          = 7'h47,
    // Diagnostics
    DIAG_SCRATCH0 = 7'h70,
    DIAG_SCRATCH1 = 7'h71,
    DIAG_SCRATCH2 = 7'h72,
    DIAG_SCRATCH3 = 7'h73,
    DIAG_CTRL     = 7'h74   // Loopback enables
  } regAddrE;

  // ==================================================================
  // Reset value of each slot
  // ==================================================================
  function automatic regByteT defaultValue(input regAddrT a);
    case (regAddrE'(a))
      CFG_VPD_ID:    defaultValue = 8'h3C;  // User variant
      CFG_VPD_VER:   defaultValue = 8'h01;
      PHY_ETH0_0:    defaultValue = 8'h41;  // Swing 4, equalizer 1
      PHY_ETH0_1:    defaultValue = 8'h05;
      PHY_ETH0_2:    defaultValue = 8'h05;
      DIAG_SCRATCH0: defaultValue = 8'hDE;
      DIAG_SCRATCH1: defaultValue = 8'hAD;
      DIAG_SCRATCH2: defaultValue = 8'hBE;
      DIAG_SCRATCH3: defaultValue = 8'hEF;
      default:       defaultValue = '0;     // Everything else clears
    endcase
  endfunction

  // ==================================================================
  // Slots that hold a writable control byte
  // ==================================================================
  function automatic logic isWritable(input regAddrT a);
    case (regAddrE'(a))
      CFG_VPD_ID, CFG_VPD_VER, CFG_VPD_REV,
      PHY_ETH0_0, PHY_ETH0_1, PHY_ETH0_2:
        isWritable = 1'b1;
      LY2_CTRL,
      LY2_MAC0, LY2_MAC1, LY2_MAC2, LY2_MAC3, LY2_MAC4, LY2_MAC5:
        isWritable = 1'b1;
      LY3_CTRL0,
      LY3_IP0, LY3_IP1, LY3_IP2, LY3_IP3:
        isWritable = 1'b1;
      ROLE_OUT0, ROLE_OUT1:
        isWritable = 1'b1;
      DIAG_SCRATCH0, DIAG_SCRATCH1, DIAG_SCRATCH2, DIAG_SCRATCH3,
      DIAG_CTRL:
        isWritable = 1'b1;
      // Status, spare and unmapped slots
      default:
        isWritable = 1'b0;
    endcase
  endfunction

endpackage
